//--- hw/trap_defs.svh
`ifndef TRAP_DEFS_SVH
`define TRAP_DEFS_SVH

////////////////////////////////////////////////////////////////////////////
// Trap controller widths
////////////////////////////////////////////////////////////////////////////

// Code address width
`define TRAP_XLEN 32

// Number of machine interrupt lines
`define TRAP_NUM_IRQ 32

// Index of one interrupt line
`define TRAP_IRQ_ID_W 5

////////////////////////////////////////////////////////////////////////////
// mtvec mode field
////////////////////////////////////////////////////////////////////////////

// Mode bits sit in the low end of mtvec
`define TRAP_MTVEC_MODE_W 2

// Vectored mode code
// Every other code falls back to direct mode
`define TRAP_MTVEC_VECTORED 2'd1

`endif

//--- hw/trap_pkg.sv
`include "trap_defs.svh"

package trap_pkg;

  ////////////////////////////////////////////////////////////////////////////
  // Data types
  ////////////////////////////////////////////////////////////////////////////

  // Code address
  // Boot, mtvec, debug halt and PC values
  typedef logic [`TRAP_XLEN-1:0] addr_t;

  // One bit per interrupt line
  typedef logic [`TRAP_NUM_IRQ-1:0] irq_vec_t;

  // Interrupt line index
  typedef logic [`TRAP_IRQ_ID_W-1:0] irq_id_t;

  ////////////////////////////////////////////////////////////////////////////
  // Run state
  ////////////////////////////////////////////////////////////////////////////

  // Out of reset until fetch enable
  // Then running, with debug halt on request
  typedef enum logic [1:0] {
    RUN_RESET  = 2'b00,
    RUN_ACTIVE = 2'b01,
    RUN_HALTED = 2'b10
  } run_state_e;

endpackage

//--- hw/irq_arbiter.sv
`timescale 1ns/10ps

`include "trap_defs.svh"

module irq_arbiter (
  // Clock and reset
  input  logic               clk_i,
  input  logic               rst_n_i,

  // Raw interrupt lines
  input  trap_pkg::irq_vec_t irq_i,

  // Software write port of mie
  input  logic               mie_we_i,
  input  trap_pkg::irq_vec_t mie_wdata_i,

  // Winning request
  output logic               irq_pending_o,
  output trap_pkg::irq_id_t  irq_id_o
);

  import trap_pkg::*;

  // Interrupt enable register
  irq_vec_t mie_q;

  // Lines that are both raised and enabled
  irq_vec_t irq_masked;

  // Index of the lowest masked line
  irq_id_t  irq_id;

  ////////////////////////////////////////////////////////////////////////////
  // mie register
  ////////////////////////////////////////////////////////////////////////////

  // All lines disabled out of reset
  // A write is visible from the following cycle
  always_ff @(posedge clk_i) begin
    if (!rst_n_i) begin
      mie_q <= '0;
    end else if (mie_we_i) begin
      mie_q <= mie_wdata_i;
    end
  end

  ////////////////////////////////////////////////////////////////////////////
  // Masking and priority
  ////////////////////////////////////////////////////////////////////////////

  // Pending only where irq_i and mie agree
  assign irq_masked = irq_i & mie_q;

  // Lowest index wins
  // Scan from the top so the last hit is the lowest set bit
  always_comb begin
    irq_id = '0;
    for (int i = `TRAP_NUM_IRQ - 1; i >= 0; i--) begin
      if (irq_masked[i]) begin
        irq_id = irq_id_t'(i);
      end
    end
  end

  // Any masked line counts as pending
  assign irq_pending_o = |irq_masked;

  // Id is only meaningful while pending
  assign irq_id_o = irq_id;

endmodule

//--- hw/run_ctrl.sv
`timescale 1ns/10ps

module run_ctrl (
  // Clock and reset
  input  logic clk_i,
  input  logic rst_n_i,

  // Run requests
  input  logic fetch_enable_i,
  input  logic debug_req_i,
  input  logic dret_i,

  // Transition strobes for the PC controller
  output logic boot_pulse_o,
  output logic halt_enter_pulse_o,
  output logic halted_o,

  // Debug module status
  output logic debug_havereset_o,
  output logic debug_running_o
);

  import trap_pkg::*;

  // Run state
  run_state_e state_q;
  run_state_e state_d;

  // Registered transition strobes
  logic boot_pulse_q;
  logic halt_pulse_q;

  // Transition decodes
  logic do_boot;
  logic do_halt;

  ////////////////////////////////////////////////////////////////////////////
  // Next state
  ////////////////////////////////////////////////////////////////////////////

  always_comb begin
    state_d = state_q;
    do_boot = 1'b0;
    do_halt = 1'b0;
    case (state_q)
      // Wait for fetch enable
      RUN_RESET: begin
        if (fetch_enable_i) begin
          state_d = RUN_ACTIVE;
          do_boot = 1'b1;
        end
      end
      // Debug request halts the hart
      RUN_ACTIVE: begin
        if (debug_req_i) begin
          state_d = RUN_HALTED;
          do_halt = 1'b1;
        end
      end
      // dret resumes without a PC change
      // further debug requests ignored here
      RUN_HALTED: begin
        if (dret_i) begin
          state_d = RUN_ACTIVE;
        end
      end
      default: begin
        state_d = RUN_RESET;
      end
    endcase
  end

  ////////////////////////////////////////////////////////////////////////////
  // State and strobe registers
  ////////////////////////////////////////////////////////////////////////////

  // Strobes are high for the one cycle after the transition edge
  always_ff @(posedge clk_i) begin
    if (!rst_n_i) begin
      state_q      <= RUN_RESET;
      boot_pulse_q <= 1'b0;
      halt_pulse_q <= 1'b0;
    end else begin
      state_q      <= state_d;
      boot_pulse_q <= do_boot;
      halt_pulse_q <= do_halt;
    end
  end

  assign boot_pulse_o       = boot_pulse_q;
  assign halt_enter_pulse_o = halt_pulse_q;

  // Status levels straight from the state
  assign halted_o          = (state_q == RUN_HALTED);
  assign debug_running_o   = (state_q == RUN_ACTIVE);
  assign debug_havereset_o = (state_q == RUN_RESET);

endmodule

//--- hw/pc_ctrl.sv
`timescale 1ns/10ps

`include "trap_defs.svh"

module pc_ctrl (
  // Clock and reset
  input  logic              clk_i,
  input  logic              rst_n_i,

  // Static target addresses
  input  trap_pkg::addr_t   boot_addr_i,
  input  trap_pkg::addr_t   mtvec_addr_i,
  input  trap_pkg::addr_t   dm_halt_addr_i,

  // From the run-state controller
  input  logic              boot_pulse_i,
  input  logic              halt_enter_pulse_i,
  input  logic              halted_i,

  // From the interrupt arbiter
  input  logic              irq_pending_i,
  input  trap_pkg::irq_id_t irq_id_i,

  // Return from trap
  input  logic              mret_i,

  // PC set and acknowledge
  output logic              pc_set_o,
  output trap_pkg::addr_t   pc_o,
  output logic              irq_ack_o,
  output trap_pkg::irq_id_t irq_id_o
);

  import trap_pkg::*;

  // Global interrupt enable
  logic    irq_en_q;

  // Set once the boot jump has gone out
  logic    booted_q;

  // Registered outputs
  logic    pc_set_q;
  logic    irq_ack_q;
  addr_t   pc_q;
  irq_id_t irq_id_q;

  // Trap vector pieces
  logic [`TRAP_MTVEC_MODE_W-1:0] trap_mode;
  addr_t   trap_base;
  addr_t   trap_offset;
  addr_t   trap_target;

  // Source selection
  logic    irq_allowed;
  logic    take_boot;
  logic    take_halt;
  logic    take_irq;

  ////////////////////////////////////////////////////////////////////////////
  // Trap target
  ////////////////////////////////////////////////////////////////////////////

  // Mode lives in the low bits of mtvec
  assign trap_mode = mtvec_addr_i[`TRAP_MTVEC_MODE_W-1:0];

  // Word aligned base
  assign trap_base = {mtvec_addr_i[`TRAP_XLEN-1:2], 2'b00};

  // Four bytes per vector slot
  assign trap_offset = addr_t'({irq_id_i, 2'b00});

  assign trap_target = (trap_mode == `TRAP_MTVEC_VECTORED) ? trap_base + trap_offset :
                                                             trap_base;

  ////////////////////////////////////////////////////////////////////////////
  // Source priority
  ////////////////////////////////////////////////////////////////////////////

  // No interrupts before boot, while halted or on halt entry
  // A PC set in flight also holds off the next one
  assign irq_allowed = irq_en_q & booted_q & ~halted_i & ~halt_enter_pulse_i & ~pc_set_q;

  // Boot first, then halt entry, then interrupt
  assign take_boot = boot_pulse_i;
  assign take_halt = halt_enter_pulse_i & ~boot_pulse_i;
  assign take_irq  = irq_pending_i & irq_allowed & ~boot_pulse_i;

  ////////////////////////////////////////////////////////////////////////////
  // Registers
  ////////////////////////////////////////////////////////////////////////////

  always_ff @(posedge clk_i) begin
    if (!rst_n_i) begin
      irq_en_q  <= 1'b1;
      booted_q  <= 1'b0;
      pc_set_q  <= 1'b0;
      irq_ack_q <= 1'b0;
      pc_q      <= '0;
      irq_id_q  <= '0;
    end else begin
      // One-cycle strobes
      pc_set_q  <= take_boot | take_halt | take_irq;
      irq_ack_q <= take_irq;

      if (boot_pulse_i) begin
        booted_q <= 1'b1;
      end

      // Target held until the next PC set
      if (take_boot) begin
        pc_q <= boot_addr_i;
      end else if (take_halt) begin
        pc_q <= dm_halt_addr_i;
      end else if (take_irq) begin
        pc_q <= trap_target;
      end

      if (take_irq) begin
        irq_id_q <= irq_id_i;
      end

      // Taking a trap masks further ones until mret
      if (take_irq) begin
        irq_en_q <= 1'b0;
      end else if (mret_i) begin
        irq_en_q <= 1'b1;
      end
    end
  end

  assign pc_set_o  = pc_set_q;
  assign pc_o      = pc_q;
  assign irq_ack_o = irq_ack_q;
  assign irq_id_o  = irq_id_q;

endmodule

//--- hw/trap_ctrl_top.sv
`timescale 1ns/10ps

module trap_ctrl_top (
  // Clock and reset
  input  logic               clk_i,
  input  logic               rst_n_i,

  // Boot control
  input  logic               fetch_enable_i,
  input  trap_pkg::addr_t    boot_addr_i,

  // Trap vector and debug halt address
  input  trap_pkg::addr_t    mtvec_addr_i,
  input  trap_pkg::addr_t    dm_halt_addr_i,

  // Interrupts
  input  trap_pkg::irq_vec_t irq_i,
  input  logic               mie_we_i,
  input  trap_pkg::irq_vec_t mie_wdata_i,
  input  logic               mret_i,

  // Debug requests
  input  logic               debug_req_i,
  input  logic               dret_i,

  // Next PC
  output logic               pc_set_o,
  output trap_pkg::addr_t    pc_o,

  // Interrupt acknowledge
  output logic               irq_ack_o,
  output trap_pkg::irq_id_t  irq_id_o,

  // Debug status
  output logic               debug_havereset_o,
  output logic               debug_running_o,
  output logic               debug_halted_o
);

  import trap_pkg::*;

  // Arbiter to PC controller
  logic    irq_pending;
  irq_id_t irq_id;

  // Run control to PC controller
  logic    boot_pulse;
  logic    halt_enter_pulse;
  logic    halted;

  ////////////////////////////////////////////////////////////////////////////
  // Interrupt arbiter
  ////////////////////////////////////////////////////////////////////////////

  irq_arbiter u_irq_arbiter (
    .clk_i         ( clk_i       ),
    .rst_n_i       ( rst_n_i     ),
    .irq_i         ( irq_i       ),
    .mie_we_i      ( mie_we_i    ),
    .mie_wdata_i   ( mie_wdata_i ),
    .irq_pending_o ( irq_pending ),
    .irq_id_o      ( irq_id      )
  );

  ////////////////////////////////////////////////////////////////////////////
  // Run state
  ////////////////////////////////////////////////////////////////////////////

  run_ctrl u_run_ctrl (
    .clk_i              ( clk_i             ),
    .rst_n_i            ( rst_n_i           ),
    .fetch_enable_i     ( fetch_enable_i    ),
    .debug_req_i        ( debug_req_i       ),
    .dret_i             ( dret_i            ),
    .boot_pulse_o       ( boot_pulse        ),
    .halt_enter_pulse_o ( halt_enter_pulse  ),
    .halted_o           ( halted            ),
    .debug_havereset_o  ( debug_havereset_o ),
    .debug_running_o    ( debug_running_o   )
  );

  // Halted level doubles as the debug status pin
  assign debug_halted_o = halted;

  ////////////////////////////////////////////////////////////////////////////
  // PC selection
  ////////////////////////////////////////////////////////////////////////////

  pc_ctrl u_pc_ctrl (
    .clk_i              ( clk_i            ),
    .rst_n_i            ( rst_n_i          ),
    .boot_addr_i        ( boot_addr_i      ),
    .mtvec_addr_i       ( mtvec_addr_i     ),
    .dm_halt_addr_i     ( dm_halt_addr_i   ),
    .boot_pulse_i       ( boot_pulse       ),
    .halt_enter_pulse_i ( halt_enter_pulse ),
    .halted_i           ( halted           ),
    .irq_pending_i      ( irq_pending      ),
    .irq_id_i           ( irq_id           ),
    .mret_i             ( mret_i           ),
    .pc_set_o           ( pc_set_o         ),
    .pc_o               ( pc_o             ),
    .irq_ack_o          ( irq_ack_o        ),
    .irq_id_o           ( irq_id_o         )
  );

endmodule

//--- tests/trap_ctrl_asserts.sv
`timescale 1ns/10ps

module trap_ctrl_asserts (
  // Clock and reset
  input logic clk_i,
  input logic rst_n_i,

  // PC and acknowledge outputs
  input logic pc_set_i,
  input logic irq_ack_i,

  // Debug status outputs
  input logic running_i,
  input logic halted_i
);

  // Failed properties for the end-of-run verdict
  int fail_count = 0;

  ////////////////////////////////////////////////////////////////////////////
  // PC set and acknowledge
  ////////////////////////////////////////////////////////////////////////////

  // One-cycle pulse
  assert property (@(posedge clk_i) disable iff (!rst_n_i) pc_set_i |=> !pc_set_i)
    else begin
      fail_count++;
      $error("pc_set_o stayed high for more than one cycle");
    end

  // Every acknowledge carries a PC set
  assert property (@(posedge clk_i) disable iff (!rst_n_i) irq_ack_i |-> pc_set_i)
    else begin
      fail_count++;
      $error("irq_ack_o high without pc_set_o");
    end

  ////////////////////////////////////////////////////////////////////////////
  // Run state
  ////////////////////////////////////////////////////////////////////////////

  // Exclusive status levels
  assert property (@(posedge clk_i) disable iff (!rst_n_i) !(halted_i && running_i))
    else begin
      fail_count++;
      $error("debug_halted_o and debug_running_o high together");
    end

  // No trap taken into a halted hart
  assert property (@(posedge clk_i) disable iff (!rst_n_i) irq_ack_i |-> !halted_i)
    else begin
      fail_count++;
      $error("irq_ack_o high while halted");
    end

endmodule

bind trap_ctrl_top trap_ctrl_asserts u_trap_ctrl_asserts (
  .clk_i       ( clk_i             ),
  .rst_n_i     ( rst_n_i           ),
  .pc_set_i    ( pc_set_o          ),
  .irq_ack_i   ( irq_ack_o         ),
  .running_i   ( debug_running_o   ),
  .halted_i    ( debug_halted_o    )
);

//--- tests/tb_trap_ctrl.sv
`timescale 1ns/10ps

`include "trap_defs.svh"

module tb_trap_ctrl;

  import trap_pkg::*;

  // Scripted stimulus length in cycles and the run limit built from it
  localparam int STIM_CYCLES = 300;
  localparam int MAX_CYCLES  = 2 * STIM_CYCLES + 200;

  // DUT pins
  logic     clk_i;
  logic     rst_n_i;
  logic     fetch_enable_i;
  addr_t    boot_addr_i;
  addr_t    mtvec_addr_i;
  addr_t    dm_halt_addr_i;
  irq_vec_t irq_i;
  logic     mie_we_i;
  irq_vec_t mie_wdata_i;
  logic     mret_i;
  logic     debug_req_i;
  logic     dret_i;
  logic     pc_set_o;
  addr_t    pc_o;
  logic     irq_ack_o;
  irq_id_t  irq_id_o;
  logic     debug_havereset_o;
  logic     debug_running_o;
  logic     debug_halted_o;

  // Error counts and run length
  int value_errs = 0;
  int other_errs = 0;
  int proto_errs = 0;
  int cycles     = 0;
  integer seed   = 95923;

  // Reference model state
  irq_vec_t m_mie;
  logic     m_en;
  logic     m_booted;
  logic     m_halted;
  logic     m_take;

  // Expectations for the cycle after each edge
  irq_id_t  exp_id_q;
  addr_t    exp_pc_q;
  logic     exp_take_q;

  trap_ctrl_top u_trap_ctrl_top (.*);

  ////////////////////////////////////////////////////////////////////////////
  // Clock and run limit
  ////////////////////////////////////////////////////////////////////////////

  initial begin
    clk_i = 1'b0;
    forever #50 clk_i = ~clk_i;
  end

  always @(posedge clk_i) begin
    cycles <= cycles + 1;
    if (cycles >= MAX_CYCLES) begin
      $display("timeout: simulation ran past %0d cycles", MAX_CYCLES);
      $display(">>> FAIL");
      $finish;
    end
  end

  ////////////////////////////////////////////////////////////////////////////
  // Reference model
  ////////////////////////////////////////////////////////////////////////////

  // Lowest raised line of a vector
  function automatic irq_id_t lowest_id(input irq_vec_t v);
    irq_id_t id;
    logic    found;
    id    = '0;
    found = 1'b0;
    for (int i = 0; i < `TRAP_NUM_IRQ; i++) begin
      if (v[i] && !found) begin
        id    = irq_id_t'(i);
        found = 1'b1;
      end
    end
    return id;
  endfunction

  // Base with low bits cleared plus four bytes per slot in vectored mode
  function automatic addr_t trap_addr(input addr_t mtvec, input irq_id_t id);
    addr_t target;
    target = mtvec & ~addr_t'(3);
    if (mtvec[1:0] == `TRAP_MTVEC_VECTORED) begin
      target = target + addr_t'(id) * 4;
    end
    return target;
  endfunction

  // Enabled line while running with the global gate open
  assign m_take = m_en & m_booted & ~m_halted & (|(irq_i & m_mie));

  always @(posedge clk_i) begin
    if (!rst_n_i) begin
      m_mie      <= '0;
      m_en       <= 1'b1;
      m_booted   <= 1'b0;
      m_halted   <= 1'b0;
      exp_id_q   <= '0;
      exp_pc_q   <= '0;
      exp_take_q <= 1'b0;
    end else begin
      if (mie_we_i) begin
        m_mie <= mie_wdata_i;
      end
      if (fetch_enable_i) begin
        m_booted <= 1'b1;
      end
      // Debug request only counts while running
      if (m_booted && !m_halted && debug_req_i) begin
        m_halted <= 1'b1;
      end else if (m_halted && dret_i) begin
        m_halted <= 1'b0;
      end
      // A take closes the gate and mret reopens it
      if (m_take) begin
        m_en <= 1'b0;
      end else if (mret_i) begin
        m_en <= 1'b1;
      end
      exp_id_q   <= lowest_id(irq_i & m_mie);
      exp_pc_q   <= trap_addr(mtvec_addr_i, lowest_id(irq_i & m_mie));
      exp_take_q <= m_take;
    end
  end

  ////////////////////////////////////////////////////////////////////////////
  // Acknowledge checks sampled mid-cycle
  ////////////////////////////////////////////////////////////////////////////

  assert property (@(negedge clk_i) disable iff (!rst_n_i) irq_ack_o == exp_take_q)
    else begin
      value_errs++;
      $display("[ERROR] irq_ack_o expected %h got %h", exp_take_q, irq_ack_o);
    end

  assert property (@(negedge clk_i) disable iff (!rst_n_i) irq_ack_o |-> irq_id_o == exp_id_q)
    else begin
      value_errs++;
      $display("[ERROR] irq_id_o expected %h got %h", exp_id_q, irq_id_o);
    end

  assert property (@(negedge clk_i) disable iff (!rst_n_i) irq_ack_o |-> pc_o == exp_pc_q)
    else begin
      value_errs++;
      $display("[ERROR] pc_o expected %h got %h", exp_pc_q, pc_o);
    end

  ////////////////////////////////////////////////////////////////////////////
  // Helper tasks
  ////////////////////////////////////////////////////////////////////////////

  task automatic expect_word(input string name, input logic [31:0] exp, input logic [31:0] got);
    assert (exp == got) else begin
      value_errs++;
      $display("[ERROR] %s expected %h got %h", name, exp, got);
    end
  endtask

  task automatic expect_ack(input logic exp, input logic got, input string when);
    assert (exp == got) else begin
      other_errs++;
      $display("interrupt acknowledge %s %s", got ? "seen unexpectedly" : "missing", when);
    end
  endtask

  // Up to limit cycles for an acknowledge
  task automatic wait_ack(input int limit, output logic seen);
    seen = 1'b0;
    for (int i = 0; i < limit && !seen; i++) begin
      @(negedge clk_i);
      if (irq_ack_o) begin
        seen = 1'b1;
      end
    end
  endtask

  task automatic pulse_mret();
    @(negedge clk_i);
    mret_i = 1'b1;
    @(negedge clk_i);
    mret_i = 1'b0;
  endtask

  ////////////////////////////////////////////////////////////////////////////
  // Stimulus
  ////////////////////////////////////////////////////////////////////////////

  initial begin
    logic     seen;
    logic     hit;
    irq_vec_t mie_val;
    irq_vec_t irq_val;
    addr_t    rnd;
    rst_n_i        = 1'b0;
    fetch_enable_i = 1'b0;
    boot_addr_i    = 32'h0000_8000;
    mtvec_addr_i   = '0;
    dm_halt_addr_i = 32'h1A11_0800;
    irq_i          = '0;
    mie_we_i       = 1'b0;
    mie_wdata_i    = '0;
    mret_i         = 1'b0;
    debug_req_i    = 1'b0;
    dret_i         = 1'b0;
    repeat (16) @(negedge clk_i);
    rst_n_i = 1'b1;

    // Reset state
    @(negedge clk_i);
    expect_word("debug_havereset_o", 32'h1, 32'(debug_havereset_o));
    expect_word("debug_running_o", 32'h0, 32'(debug_running_o));
    expect_word("debug_halted_o", 32'h0, 32'(debug_halted_o));
    expect_word("pc_set_o", 32'h0, 32'(pc_set_o));
    expect_word("irq_ack_o", 32'h0, 32'(irq_ack_o));
    expect_word("irq_id_o", 32'h0, 32'(irq_id_o));
    expect_word("pc_o", 32'h0, pc_o);

    // Boot with a fixed two-edge latency
    fetch_enable_i = 1'b1;
    @(negedge clk_i);
    expect_word("debug_running_o", 32'h1, 32'(debug_running_o));
    expect_word("debug_havereset_o", 32'h0, 32'(debug_havereset_o));
    @(negedge clk_i);
    expect_word("pc_set_o", 32'h1, 32'(pc_set_o));
    expect_word("pc_o", boot_addr_i, pc_o);

    // Random mie and lines with mtvec mode cycling through all four codes
    for (int r = 0; r < 16; r++) begin
      mie_val = $random(seed);
      irq_val = $random(seed);
      rnd     = $random(seed);
      if (r % 4 == 3) begin
        irq_val = irq_val & ~mie_val;
      end
      hit = |(irq_val & mie_val);
      @(negedge clk_i);
      mie_we_i     = 1'b1;
      mie_wdata_i  = mie_val;
      mtvec_addr_i = {rnd[31:2], 2'(r % 4)};
      @(negedge clk_i);
      mie_we_i = 1'b0;
      irq_i    = irq_val;
      wait_ack(6, seen);
      expect_ack(hit, seen, "in masked priority round");
      irq_i = '0;
      pulse_mret();
    end

    // Pending line held across the global enable gate
    mie_we_i    = 1'b1;
    mie_wdata_i = '1;
    @(negedge clk_i);
    mie_we_i = 1'b0;
    irq_i    = irq_vec_t'(1) << 9;
    wait_ack(6, seen);
    expect_ack(1'b1, seen, "for first take of held line");
    wait_ack(5, seen);
    expect_ack(1'b0, seen, "before mret");
    pulse_mret();
    wait_ack(6, seen);
    expect_ack(1'b1, seen, "after mret");
    irq_i = '0;
    pulse_mret();

    // Debug halt with no line raised
    @(negedge clk_i);
    debug_req_i = 1'b1;
    @(negedge clk_i);
    debug_req_i = 1'b0;
    expect_word("debug_halted_o", 32'h1, 32'(debug_halted_o));
    expect_word("debug_running_o", 32'h0, 32'(debug_running_o));
    @(negedge clk_i);
    expect_word("pc_set_o", 32'h1, 32'(pc_set_o));
    expect_word("pc_o", dm_halt_addr_i, pc_o);

    // Held off while halted and taken after dret
    irq_i = irq_vec_t'(1) << 20;
    wait_ack(6, seen);
    expect_ack(1'b0, seen, "while halted");
    dret_i = 1'b1;
    @(negedge clk_i);
    dret_i = 1'b0;
    wait_ack(6, seen);
    expect_ack(1'b1, seen, "after dret");
    expect_word("debug_running_o", 32'h1, 32'(debug_running_o));
    irq_i = '0;
    repeat (4) @(negedge clk_i);

    proto_errs = u_trap_ctrl_top.u_trap_ctrl_asserts.fail_count;
    $display("errors: value %0d, other %0d, protocol %0d", value_errs, other_errs, proto_errs);
    if (value_errs + other_errs + proto_errs == 0) begin
      $display(">>> PASS");
    end else begin
      $display(">>> FAIL");
    end
    $finish;
  end

endmodule

//--- sim.f
+incdir+hw
hw/trap_pkg.sv
hw/irq_arbiter.sv
hw/run_ctrl.sv
hw/pc_ctrl.sv
hw/trap_ctrl_top.sv
tests/trap_ctrl_asserts.sv
tests/tb_trap_ctrl.sv

//--- Makefile
VERILATOR ?= verilator
VFLAGS    ?= --binary --timing --assert -j 0
LINTFLAGS ?= --lint-only -Wall --timing
TOP       := tb_trap_ctrl
FILELIST  := sim.f
BUILD_DIR := obj_dir
PASS_MSG  := >>> PASS

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD_DIR)

run: build
	@out="$$(./$(BUILD_DIR)/V$(TOP))"; echo "$$out"; \
	echo "$$out" | grep -qxF '$(PASS_MSG)'

lint:
	$(VERILATOR) $(LINTFLAGS) --top-module $(TOP) -f $(FILELIST)

clean:
	rm -rf $(BUILD_DIR)
